/* src/csr_pkg.sv */
// csr address, data word, op enum, access command struct, fixed addresses, source select
package csr_pkg;

  // 12-bit csr address space
  typedef logic [11:0] csr_addr_t;

  typedef logic [31:0] word;

  // i forms take zimm as the source
  typedef enum logic [2:0] {
    op_none,
    op_rw,
    op_rs,
    op_rc,
    op_rwi,
    op_rsi,
    op_rci
  } csr_op_t;

  // one access from the core, valid when enable is high
  typedef struct packed {
    logic      enable;
    csr_addr_t addr;
    csr_op_t   op;
    logic [4:0] zimm;
    word       rs1_data;
  } csr_cmd_t;

  // threshold and nesting depth readout
  localparam csr_addr_t MIntThreshAddr = 12'h347;
  localparam csr_addr_t StackDepthAddr = 12'h350;

  // operand of an op, zimm zero extended for the immediate forms
  function automatic word csr_src(csr_cmd_t cmd);
    word src;
    case (cmd.op)
      op_rwi, op_rsi, op_rci: src = word'(cmd.zimm);
      default: src = cmd.rs1_data;
    endcase
    return src;
  endfunction

endpackage

/* src/clic_pkg.sv */
// priority sizing, pc type, entry, arbiter result, stack frame and core request structs
package clic_pkg;

  // eight priority levels
  localparam int PrioWidth = 3;

  // one saved frame per level
  localparam int StackDepth = 8;

  typedef logic [PrioWidth-1:0] prio_t;

  // word aligned instruction address, low two bits dropped
  typedef logic [29:0] pc_t;

  // 5 bits in total so a whole entry fits in zimm
  typedef struct packed {
    prio_t prio;
    logic  enabled;
    logic  pended;
  } entry_t;

  // winner of one table slice
  typedef struct packed {
    logic       hit;
    prio_t      prio;
    logic [7:0] vec;
  } arb_result_t;

  // state saved on a take, restored on mret
  typedef struct packed {
    pc_t   pc;
    prio_t thresh;
  } frame_t;

  // payload held stable while req is high
  typedef struct packed {
    logic [7:0] vec;
    pc_t        addr;
  } int_req_t;

endpackage

/* src/csr_reg.sv */
// csr_reg: one csr of any payload type with software ops and a hardware write port
`timescale 1ns/1ns

module csr_reg #(
  parameter type payload_t = logic [31:0],
  parameter csr_pkg::csr_addr_t Addr = 12'h000
) (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::csr_cmd_t  cmd,
  input  logic               hw_write,
  input  payload_t           hw_data,
  output payload_t           data
);

  localparam int Width = $bits(payload_t);

  logic             sw_write;
  logic [Width-1:0] cur;
  logic [Width-1:0] src;
  logic [Width-1:0] next;

  // own address decode
  assign sw_write = cmd.enable && (cmd.addr == Addr);

  assign cur = data;

  // operand cut down to the payload width
  assign src = Width'(csr_pkg::csr_src(cmd));

  always_comb begin
    case (cmd.op)
      csr_pkg::op_rw, csr_pkg::op_rwi: next = src;
      // set bits
      csr_pkg::op_rs, csr_pkg::op_rsi: next = cur | src;
      // clear bits
      csr_pkg::op_rc, csr_pkg::op_rci: next = cur & ~src;
      default: next = cur;
    endcase
  end

  // hardware side wins a same cycle collision
  always_ff @(posedge clk) begin
    if (reset) begin
      data <= '0;
    end else if (hw_write) begin
      data <= hw_data;
    end else if (sw_write) begin
      data <= payload_t'(next);
    end
  end

endmodule

/* src/clic_csr_bank.sv */
// clic_csr_bank: vector, entry and threshold csrs, depth readout, read mux, pended updates
`timescale 1ns/1ns

module clic_csr_bank #(
  parameter int VecSize      = 8,
  parameter int VecCsrBase   = 'hb00,
  parameter int EntryCsrBase = 'hb20
) (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::csr_cmd_t  cmd,
  input  logic [VecSize-1:0] irq,
  input  logic               take,
  input  logic [7:0]         take_vec,
  input  logic               thresh_write,
  input  clic_pkg::prio_t    thresh_data,
  input  logic [3:0]         stack_count,
  output clic_pkg::entry_t   entries [VecSize],
  output clic_pkg::pc_t      vec_table [VecSize],
  output clic_pkg::prio_t    thresh,
  output csr_pkg::word       out
);

  // vectors, entries, threshold, depth
  localparam int NumRegs = 2 * VecSize + 2;

  logic [NumRegs-1:0] match;
  csr_pkg::word       rd [NumRegs];

  for (genvar k = 0; k < VecSize; k++) begin : gen_vec
    logic             take_hit;
    clic_pkg::entry_t hw_entry;

    // vector address, software only
    csr_reg #(
      .payload_t(clic_pkg::pc_t),
      .Addr(csr_pkg::csr_addr_t'(VecCsrBase + k))
    ) vec_reg (
      .clk,
      .reset,
      .cmd,
      .hw_write(1'b0),
      .hw_data('0),
      .data(vec_table[k])
    );

    assign take_hit = take && (take_vec == 8'(k));

    // live irq line keeps pended set even on a take
    always_comb begin
      hw_entry = entries[k];
      hw_entry.pended = irq[k];
    end

    csr_reg #(
      .payload_t(clic_pkg::entry_t),
      .Addr(csr_pkg::csr_addr_t'(EntryCsrBase + k))
    ) entry_reg (
      .clk,
      .reset,
      .cmd,
      .hw_write(irq[k] || take_hit),
      .hw_data(hw_entry),
      .data(entries[k])
    );

    // read mux legs
    assign match[k] = (cmd.addr == csr_pkg::csr_addr_t'(VecCsrBase + k));
    assign rd[k] = csr_pkg::word'(vec_table[k]);
    assign match[VecSize+k] = (cmd.addr == csr_pkg::csr_addr_t'(EntryCsrBase + k));
    assign rd[VecSize+k] = csr_pkg::word'(entries[k]);
  end

  // threshold, also loaded by take and mret
  csr_reg #(
    .payload_t(clic_pkg::prio_t),
    .Addr(csr_pkg::MIntThreshAddr)
  ) thresh_reg (
    .clk,
    .reset,
    .cmd,
    .hw_write(thresh_write),
    .hw_data(thresh_data),
    .data(thresh)
  );

  assign match[2*VecSize] = (cmd.addr == csr_pkg::MIntThreshAddr);
  assign rd[2*VecSize] = csr_pkg::word'(thresh);

  // depth is read only, no register behind it
  assign match[2*VecSize+1] = (cmd.addr == csr_pkg::StackDepthAddr);
  assign rd[2*VecSize+1] = csr_pkg::word'(stack_count);

  // unmapped address reads zero
  always_comb begin
    out = '0;
    for (int i = 0; i < NumRegs; i++) begin
      if (match[i]) begin
        out = out | rd[i];
      end
    end
  end

  // overlapping bases would alias two registers
  a_one_match: assert property (@(posedge clk) disable iff (reset) $onehot0(match));

endmodule

/* src/clic_arbiter.sv */
// clic_arbiter: highest priority enabled and pending entry in one slice of the table
`timescale 1ns/1ns

module clic_arbiter #(
  parameter int NumVec = 4,
  parameter int Base   = 0
) (
  input  clic_pkg::entry_t      entries [NumVec],
  output clic_pkg::arb_result_t result
);

  // running best, stage k has seen entries 0..k-1
  clic_pkg::arb_result_t chain [NumVec+1];

  // empty start, no hit
  assign chain[0] = '0;

  for (genvar k = 0; k < NumVec; k++) begin : gen_chain
    logic cand;
    logic beats;

    // enabled and pending
    assign cand = entries[k].enabled && entries[k].pended;

    // strict compare so a tie stays with the lower index
    assign beats = cand && (!chain[k].hit || (entries[k].prio > chain[k].prio));

    // global index reported
    assign chain[k+1] = beats ? '{hit: 1'b1, prio: entries[k].prio, vec: 8'(Base + k)}
                              : chain[k];
  end

  assign result = chain[NumVec];

endmodule

/* src/epc_stack.sv */
// epc_stack: lifo of saved pc and threshold frames with depth count
`timescale 1ns/1ns

module epc_stack (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic             pop,
  input  clic_pkg::frame_t frame_in,
  output clic_pkg::frame_t top,
  output logic [3:0]       count
);

  localparam int IdxWidth = $clog2(clic_pkg::StackDepth);

  clic_pkg::frame_t    mem [clic_pkg::StackDepth];
  logic [IdxWidth-1:0] wr_idx;
  logic [IdxWidth-1:0] top_idx;

  // count doubles as the next free slot
  assign wr_idx = count[IdxWidth-1:0];
  assign top_idx = IdxWidth'(count - 4'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (push) begin
      count <= count + 4'd1;
    end else if (pop) begin
      count <= count - 4'd1;
    end
  end

  // frame storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_idx] <= frame_in;
    end
  end

  // zero when empty
  assign top = (count == '0) ? '0 : mem[top_idx];

  // nesting deeper than the level count
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> (count < 4'(clic_pkg::StackDepth)));

  // mret without a matching take
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop |-> (count != '0));

  a_no_push_pop: assert property (@(posedge clk) disable iff (reset) !(push && pop));

endmodule

/* src/clic_take_ctrl.sv */
// clic_take_ctrl: combines slice winners, threshold compare, req/ack FSM, stack push and pop
`timescale 1ns/1ns

module clic_take_ctrl #(
  parameter int VecSize = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  clic_pkg::arb_result_t lo,
  input  clic_pkg::arb_result_t hi,
  input  clic_pkg::prio_t       thresh,
  input  clic_pkg::pc_t         vec_table [VecSize],
  input  clic_pkg::pc_t         pc_in,
  input  logic                  ret,
  input  clic_pkg::frame_t      top,
  input  logic                  ack,
  output logic                  take,
  output logic [7:0]            take_vec,
  output logic                  thresh_write,
  output clic_pkg::prio_t       thresh_data,
  output logic                  push,
  output logic                  pop,
  output clic_pkg::frame_t      frame,
  output logic                  req,
  output clic_pkg::int_req_t    int_req
);

  localparam int IdxWidth = $clog2(VecSize);

  // four phase handshake states
  typedef enum logic [1:0] {
    st_idle,
    st_wait_ack,
    st_wait_low
  } state_t;

  state_t                state;
  clic_pkg::arb_result_t winner;

  // tie goes to the lower half
  always_comb begin
    if (lo.hit && (!hi.hit || (lo.prio >= hi.prio))) begin
      winner = lo;
    end else begin
      winner = hi;
    end
  end

  // mret in the same cycle holds the take back
  assign take = (state == st_idle) && !ack && !ret && winner.hit && (winner.prio > thresh);
  assign take_vec = winner.vec;

  // new level on take, saved level on return
  assign thresh_write = take || ret;
  assign thresh_data = ret ? top.thresh : winner.prio;

  assign push = take;
  assign pop = ret;
  assign frame = '{pc: pc_in, thresh: thresh};

  assign req = (state == st_wait_ack);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (take) state <= st_wait_ack;
        // req drops on the edge that sees ack
        st_wait_ack: if (ack) state <= st_wait_low;
        // core must release ack first
        st_wait_low: if (!ack) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // payload latched once per take
  always_ff @(posedge clk) begin
    if (take) begin
      int_req.vec <= winner.vec;
      int_req.addr <= vec_table[winner.vec[IdxWidth-1:0]];
    end
  end

  a_payload_stable: assert property (@(posedge clk) disable iff (reset)
    req |=> (!req || $stable(int_req)));

endmodule

/* src/n_clic.sv */
// n_clic: top level wiring csr bank, two slice arbiters, take controller and epc stack
`timescale 1ns/1ns

module n_clic #(
  parameter int VecSize      = 8,
  parameter int VecCsrBase   = 'hb00,
  parameter int EntryCsrBase = 'hb20
) (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::csr_cmd_t  cmd,
  input  logic [VecSize-1:0] irq,
  input  clic_pkg::pc_t      pc_in,
  input  logic               ret,
  input  logic               ack,
  output csr_pkg::word       out,
  output logic               req,
  output clic_pkg::int_req_t int_req,
  output clic_pkg::pc_t      epc
);

  localparam int Half = VecSize / 2;

  clic_pkg::entry_t      entries [VecSize];
  clic_pkg::pc_t         vec_table [VecSize];
  clic_pkg::prio_t       thresh;
  clic_pkg::arb_result_t lo_result;
  clic_pkg::arb_result_t hi_result;
  logic                  take;
  logic [7:0]            take_vec;
  logic                  thresh_write;
  clic_pkg::prio_t       thresh_data;
  logic                  push;
  logic                  pop;
  clic_pkg::frame_t      frame;
  clic_pkg::frame_t      top;
  logic [3:0]            stack_count;

  // table must split evenly and fit the entry csr window
  if ((VecSize % 2 != 0) || (VecSize < 2) || (VecSize > 32)) begin : gen_bad_size
    $error("VecSize must be even and in 2..32");
  end

  clic_csr_bank #(
    .VecSize(VecSize),
    .VecCsrBase(VecCsrBase),
    .EntryCsrBase(EntryCsrBase)
  ) bank (.*);

  // lower slice
  clic_arbiter #(
    .NumVec(Half),
    .Base(0)
  ) arb_lo (
    .entries(entries[0:Half-1]),
    .result(lo_result)
  );

  // upper slice
  clic_arbiter #(
    .NumVec(Half),
    .Base(Half)
  ) arb_hi (
    .entries(entries[Half:VecSize-1]),
    .result(hi_result)
  );

  clic_take_ctrl #(
    .VecSize(VecSize)
  ) ctrl (
    .clk,
    .reset,
    .lo(lo_result),
    .hi(hi_result),
    .thresh,
    .vec_table,
    .pc_in,
    .ret,
    .top,
    .ack,
    .take,
    .take_vec,
    .thresh_write,
    .thresh_data,
    .push,
    .pop,
    .frame,
    .req,
    .int_req
  );

  epc_stack stack (
    .clk,
    .reset,
    .push,
    .pop,
    .frame_in(frame),
    .top,
    .count(stack_count)
  );

  // return address visible before the pop
  assign epc = top.pc;

endmodule

/* tb/n_clic_tb.sv */
// n_clic_tb: clock, reset, csr and irq stimulus, reference model, core side ack, checks, timeout
`timescale 1ns/1ns

module n_clic_tb;

  localparam int VecSize      = 8;
  localparam int VecCsrBase   = 'hb00;
  localparam int EntryCsrBase = 'hb20;
  localparam int HalfPeriod   = 4;
  localparam int PcBits       = $bits(clic_pkg::pc_t);
  localparam int EntryBits    = $bits(clic_pkg::entry_t);
  localparam int NumCsrOps    = 48;
  localparam int SlowAck      = 12;
  localparam int Seed         = 32'h58ca_d536;

  // cycle budget of each test sequence
  localparam int CyclesReset  = 5;
  localparam int CyclesCsr    = 150;
  localparam int CyclesSingle = 40;
  localparam int CyclesArb    = 120;
  localparam int CyclesMask   = 60;
  localparam int CyclesNest   = 60;
  localparam int CyclesBack   = 150;
  localparam int TimeoutCycles = CyclesReset + CyclesCsr + CyclesSingle + CyclesArb
                               + CyclesMask + CyclesNest + CyclesBack + 200;

  logic               clk = 1'b0;
  logic               reset;
  csr_pkg::csr_cmd_t  cmd;
  logic [VecSize-1:0] irq;
  clic_pkg::pc_t      pc_in;
  logic               ret;
  logic               ack;
  csr_pkg::word       out;
  logic               req;
  clic_pkg::int_req_t int_req;
  clic_pkg::pc_t      epc;

  // shadow of the csrs and the stack
  clic_pkg::pc_t      mdl_vec [VecSize];
  clic_pkg::entry_t   mdl_ent [VecSize];
  clic_pkg::prio_t    mdl_thresh;
  clic_pkg::frame_t   mdl_stack [$];
  // payloads the core should see, in order
  clic_pkg::int_req_t exp_reqs [$];
  clic_pkg::int_req_t next_exp;

  int   cycle_count = 0;
  int   ack_delay = 0;
  logic ack_slow = 1'b0;
  logic req_seen = 1'b0;

  n_clic #(
    .VecSize(VecSize),
    .VecCsrBase(VecCsrBase),
    .EntryCsrBase(EntryCsrBase)
  ) dut0 (
    .clk,
    .reset,
    .cmd,
    .irq,
    .pc_in,
    .ret,
    .ack,
    .out,
    .req,
    .int_req,
    .epc
  );

  always #HalfPeriod clk = ~clk;

  task automatic stop_on_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic abort_run(string why);
    $display("%s", why);
    stop_on_failure();
  endtask

  task automatic check_word(string name, csr_pkg::word exp, csr_pkg::word act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_req(string name, clic_pkg::int_req_t exp, clic_pkg::int_req_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected vec %0d addr %h actual vec %0d addr %h",
               $time, name, exp.vec, exp.addr, act.vec, act.addr);
      stop_on_failure();
    end
  endtask

  task automatic check_pc(string name, clic_pkg::pc_t exp, clic_pkg::pc_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  function automatic csr_pkg::csr_addr_t vec_addr(int k);
    return csr_pkg::csr_addr_t'(VecCsrBase + k);
  endfunction

  function automatic csr_pkg::csr_addr_t entry_addr(int k);
    return csr_pkg::csr_addr_t'(EntryCsrBase + k);
  endfunction

  // prio, enabled, pended from msb down
  function automatic csr_pkg::word entry_word(clic_pkg::prio_t prio, logic en);
    return csr_pkg::word'({prio, en, 1'b0});
  endfunction

  // result of one csr op before truncation
  function automatic csr_pkg::word ref_csr_op(csr_pkg::csr_op_t op, csr_pkg::word cur,
                                              csr_pkg::word rs1, logic [4:0] zimm);
    csr_pkg::word src;
    if (op == csr_pkg::op_rwi || op == csr_pkg::op_rsi || op == csr_pkg::op_rci) begin
      src = {27'b0, zimm};
    end else begin
      src = rs1;
    end
    case (op)
      csr_pkg::op_rw, csr_pkg::op_rwi: return src;
      csr_pkg::op_rs, csr_pkg::op_rsi: return cur | src;
      csr_pkg::op_rc, csr_pkg::op_rci: return cur & ~src;
      default: return cur;
    endcase
  endfunction

  // highest prio enabled and pending, lowest index on a tie, -1 if masked
  function automatic int ref_winner();
    int best;
    best = -1;
    for (int k = 0; k < VecSize; k++) begin
      if (mdl_ent[k].enabled && mdl_ent[k].pended) begin
        if (best < 0 || mdl_ent[k].prio > mdl_ent[best].prio) begin
          best = k;
        end
      end
    end
    if (best >= 0 && mdl_ent[best].prio <= mdl_thresh) begin
      best = -1;
    end
    return best;
  endfunction

  function automatic csr_pkg::word ref_read(csr_pkg::csr_addr_t addr);
    if (addr >= VecCsrBase && addr < VecCsrBase + VecSize) begin
      return csr_pkg::word'(mdl_vec[addr - VecCsrBase]);
    end else if (addr >= EntryCsrBase && addr < EntryCsrBase + VecSize) begin
      return csr_pkg::word'(mdl_ent[addr - EntryCsrBase]);
    end else if (addr == csr_pkg::MIntThreshAddr) begin
      return csr_pkg::word'(mdl_thresh);
    end else if (addr == csr_pkg::StackDepthAddr) begin
      return csr_pkg::word'(mdl_stack.size());
    end
    return '0;
  endfunction

  // depth readout ignores writes
  task automatic model_write(csr_pkg::csr_addr_t addr, csr_pkg::csr_op_t op,
                             csr_pkg::word rs1, logic [4:0] zimm);
    csr_pkg::word res;
    res = ref_csr_op(op, ref_read(addr), rs1, zimm);
    if (addr >= VecCsrBase && addr < VecCsrBase + VecSize) begin
      mdl_vec[addr - VecCsrBase] = res[PcBits-1:0];
    end else if (addr >= EntryCsrBase && addr < EntryCsrBase + VecSize) begin
      mdl_ent[addr - EntryCsrBase] = res[EntryBits-1:0];
    end else if (addr == csr_pkg::MIntThreshAddr) begin
      mdl_thresh = res[clic_pkg::PrioWidth-1:0];
    end
  endtask

  task automatic tick();
    @(negedge clk);
  endtask

  task automatic csr_write(csr_pkg::csr_op_t op, csr_pkg::csr_addr_t addr,
                           csr_pkg::word rs1, logic [4:0] zimm);
    cmd = '{enable: 1'b1, addr: addr, op: op, zimm: zimm, rs1_data: rs1};
    model_write(addr, op, rs1, zimm);
    tick();
    cmd = '0;
  endtask

  // out is combinational and sampled mid low phase
  task automatic read_check(csr_pkg::csr_addr_t addr);
    cmd = '{enable: 1'b0, addr: addr, op: csr_pkg::op_none, zimm: '0, rs1_data: '0};
    #(HalfPeriod / 2);
    check_word($sformatf("out[%h]", addr), ref_read(addr), out);
    tick();
  endtask

  // one cycle high pulse that sets pended at the next edge
  task automatic pulse_irq(logic [VecSize-1:0] mask);
    irq = mask;
    for (int k = 0; k < VecSize; k++) begin
      if (mask[k]) begin
        mdl_ent[k].pended = 1'b1;
      end
    end
    tick();
    irq = '0;
  endtask

  // called one edge ahead of the take
  task automatic expect_take();
    int w;
    clic_pkg::int_req_t exp;
    w = ref_winner();
    if (w < 0) begin
      abort_run("model has no eligible entry where a take was expected");
    end
    pc_in = clic_pkg::pc_t'($urandom());
    ack_delay = ack_slow ? SlowAck : int'($urandom_range(5, 0));
    exp.vec = 8'(w);
    exp.addr = mdl_vec[w];
    exp_reqs.push_back(exp);
    mdl_stack.push_back('{pc: pc_in, thresh: mdl_thresh});
    mdl_thresh = mdl_ent[w].prio;
    mdl_ent[w].pended = 1'b0;
  endtask

  task automatic wait_req_rise();
    tick();
    if (req !== 1'b1) begin
      abort_run("req did not rise on the edge after the take");
    end
  endtask

  // idle again once ack is seen low
  task automatic wait_handshake_end();
    while (req) begin
      tick();
    end
    while (ack) begin
      tick();
    end
  endtask

  task automatic take_and_complete();
    expect_take();
    wait_req_rise();
    wait_handshake_end();
  endtask

  // epc checked before the pop
  task automatic do_ret();
    clic_pkg::frame_t f;
    if (mdl_stack.size() == 0) begin
      abort_run("return issued with an empty model stack");
    end
    f = mdl_stack.pop_back();
    check_pc("epc", f.pc, epc);
    mdl_thresh = f.thresh;
    ret = 1'b1;
    tick();
    ret = 1'b0;
  endtask

  // take whatever is eligible and return when nothing is
  task automatic drain();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      if (ref_winner() >= 0) begin
        take_and_complete();
      end else if (mdl_stack.size() != 0) begin
        do_ret();
      end else begin
        busy = 1'b0;
      end
    end
  endtask

  // core side acks after a delay and releases ack the same delay after req falls
  initial begin : core_side
    ack = 1'b0;
    forever begin
      @(negedge clk);
      if (req && !ack) begin
        repeat (ack_delay) @(negedge clk);
        ack <= 1'b1;
        @(negedge clk);
        while (req) @(negedge clk);
        repeat (ack_delay) @(negedge clk);
        ack <= 1'b0;
      end
    end
  end

  // compares every rising req with the next expected payload
  always @(negedge clk) begin : req_monitor
    if (!reset && req && !req_seen) begin
      if (ack) begin
        abort_run("req rose before ack was seen low");
      end else if (exp_reqs.size() == 0) begin
        abort_run("req rose with no take expected");
      end else begin
        next_exp = exp_reqs.pop_front();
        check_req("int_req", next_exp, int_req);
      end
    end
    req_seen = req;
  end

  always @(posedge clk) begin : watchdog
    cycle_count = cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", TimeoutCycles));
    end
  end

  initial begin : stimulus
    int                 sel;
    csr_pkg::csr_addr_t addr;
    csr_pkg::csr_op_t   op;
    csr_pkg::word       rs1;
    logic [4:0]         zimm;
    clic_pkg::prio_t    tie_a;
    clic_pkg::prio_t    tie_b;

    void'($urandom(Seed));
    reset = 1'b1;
    cmd = '0;
    irq = '0;
    pc_in = '0;
    ret = 1'b0;
    for (int k = 0; k < VecSize; k++) begin
      mdl_vec[k] = '0;
      mdl_ent[k] = '0;
    end
    mdl_thresh = '0;
    repeat (CyclesReset) @(negedge clk);
    reset = 1'b0;
    if (req !== 1'b0) begin
      abort_run("req is not low after reset");
    end
    read_check(csr_pkg::MIntThreshAddr);
    read_check(csr_pkg::StackDepthAddr);

    // random csr ops with the pended bit kept clear on entries
    for (int i = 0; i < NumCsrOps; i++) begin
      sel = int'($urandom_range(2 * VecSize, 0));
      rs1 = $urandom();
      zimm = 5'($urandom());
      op = csr_pkg::csr_op_t'($urandom_range(6, 1));
      if (sel < VecSize) begin
        addr = vec_addr(sel);
      end else if (sel < 2 * VecSize) begin
        addr = entry_addr(sel - VecSize);
        rs1[0] = 1'b0;
        zimm[0] = 1'b0;
      end else begin
        addr = csr_pkg::MIntThreshAddr;
      end
      csr_write(op, addr, rs1, zimm);
      read_check(addr);
    end
    csr_write(csr_pkg::op_rw, csr_pkg::StackDepthAddr, $urandom(), '0);
    read_check(csr_pkg::StackDepthAddr);
    read_check(12'h123);
    for (int k = 0; k < VecSize; k++) begin
      csr_write(csr_pkg::op_rw, entry_addr(k), '0, '0);
    end
    csr_write(csr_pkg::op_rw, csr_pkg::MIntThreshAddr, '0, '0);

    // single take
    csr_write(csr_pkg::op_rw, entry_addr(2), entry_word(3'd5, 1'b1), '0);
    pulse_irq(8'h04);
    take_and_complete();
    read_check(entry_addr(2));
    read_check(csr_pkg::MIntThreshAddr);
    do_ret();
    read_check(csr_pkg::MIntThreshAddr);

    // arbitration over both halves with a tie across and a tie in the upper half
    tie_a = clic_pkg::prio_t'($urandom_range(7, 1));
    tie_b = clic_pkg::prio_t'($urandom_range(7, 1));
    csr_write(csr_pkg::op_rw, entry_addr(0), '0, '0);
    csr_write(csr_pkg::op_rw, entry_addr(1), entry_word(tie_a, 1'b1), '0);
    csr_write(csr_pkg::op_rw, entry_addr(2),
              entry_word(clic_pkg::prio_t'($urandom_range(7, 1)), 1'b1), '0);
    // disabled but pulsed
    csr_write(csr_pkg::op_rw, entry_addr(3), entry_word(3'd7, 1'b0), '0);
    csr_write(csr_pkg::op_rw, entry_addr(4), '0, '0);
    csr_write(csr_pkg::op_rw, entry_addr(5), entry_word(tie_a, 1'b1), '0);
    csr_write(csr_pkg::op_rw, entry_addr(6), entry_word(tie_b, 1'b1), '0);
    csr_write(csr_pkg::op_rw, entry_addr(7), entry_word(tie_b, 1'b1), '0);
    pulse_irq(8'hee);
    drain();
    csr_write(csr_pkg::op_rci, entry_addr(3), '0, 5'b00001);
    for (int k = 0; k < VecSize; k++) begin
      read_check(entry_addr(k));
    end

    // prio equal to the threshold is masked
    csr_write(csr_pkg::op_rw, entry_addr(5), entry_word(3'd3, 1'b1), '0);
    csr_write(csr_pkg::op_rw, csr_pkg::MIntThreshAddr, 32'd3, '0);
    pulse_irq(8'h20);
    repeat (20) begin
      tick();
      if (req !== 1'b0) begin
        abort_run("req rose for an entry at the threshold");
      end
    end
    csr_write(csr_pkg::op_rw, csr_pkg::MIntThreshAddr, 32'd2, '0);
    take_and_complete();
    do_ret();
    read_check(csr_pkg::MIntThreshAddr);
    csr_write(csr_pkg::op_rw, csr_pkg::MIntThreshAddr, '0, '0);

    // low prio take preempted by a high prio take
    csr_write(csr_pkg::op_rw, entry_addr(0), entry_word(3'd2, 1'b1), '0);
    csr_write(csr_pkg::op_rw, entry_addr(4), entry_word(3'd6, 1'b1), '0);
    pulse_irq(8'h01);
    take_and_complete();
    pulse_irq(8'h10);
    take_and_complete();
    read_check(csr_pkg::StackDepthAddr);
    do_ret();
    read_check(csr_pkg::MIntThreshAddr);
    do_ret();
    read_check(csr_pkg::MIntThreshAddr);

    // slow ack while more irqs arrive mid handshake
    csr_write(csr_pkg::op_rw, entry_addr(1), entry_word(3'd2, 1'b1), '0);
    csr_write(csr_pkg::op_rw, entry_addr(2), entry_word(3'd5, 1'b1), '0);
    csr_write(csr_pkg::op_rw, entry_addr(6), entry_word(3'd5, 1'b1), '0);
    csr_write(csr_pkg::op_rw, entry_addr(7), entry_word(3'd7, 1'b1), '0);
    ack_slow = 1'b1;
    pulse_irq(8'h02);
    expect_take();
    wait_req_rise();
    pulse_irq(8'hc4);
    if (req !== 1'b1) begin
      abort_run("req dropped before the core raised ack");
    end
    wait_handshake_end();
    drain();
    ack_slow = 1'b0;
    for (int k = 0; k < VecSize; k++) begin
      read_check(entry_addr(k));
    end
    read_check(csr_pkg::MIntThreshAddr);
    read_check(csr_pkg::StackDepthAddr);

    if (exp_reqs.size() == 0 && mdl_stack.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      abort_run("expected interrupt requests or frames are still outstanding");
    end
  end

endmodule

/* project.f */
src/csr_pkg.sv
src/clic_pkg.sv
src/csr_reg.sv
src/clic_csr_bank.sv
src/clic_arbiter.sv
src/epc_stack.sv
src/clic_take_ctrl.sv
src/n_clic.sv
tb/n_clic_tb.sv
